//--- build.f
design/mips_isa_pkg.sv
design/mips_pipe_pkg.sv
design/alu.sv
design/regfile.sv
design/controller.sv
design/hazard_unit.sv
design/datapath.sv
design/mips_core.sv
sim/tb_mem.sv
sim/mips_core_tb.sv

//--- design/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [mips_pipe_pkg::xlen-1:0] a,
    input  logic [mips_pipe_pkg::xlen-1:0] b,
    input  mips_pipe_pkg::alu_op_t         control,
    output logic [mips_pipe_pkg::xlen-1:0] result,
    output logic                           zero
);

    logic lt;

    // Signed compare for slt
    assign lt = $signed(a) < $signed(b);

    always_comb begin
        case (control)
            mips_pipe_pkg::alu_and: result = a & b;
            mips_pipe_pkg::alu_or:  result = a | b;
            mips_pipe_pkg::alu_add: result = a + b;
            mips_pipe_pkg::alu_sub: result = a - b;
            mips_pipe_pkg::alu_slt: result = {{(mips_pipe_pkg::xlen-1){1'b0}}, lt};
            default:                result = '0;
        endcase
    end

    // beq compares through sub
    assign zero = (result == '0);

endmodule

//--- design/controller.sv
`timescale 1ns/1ps

module controller (
    input  logic [mips_pipe_pkg::xlen-1:0] instr_id,
    output logic                           memtoreg_id,
    output logic                           memwrite_id,
    output logic                           alusrc_id,
    output logic                           regdst_id,
    output logic                           regwrite_id,
    output logic                           jump_id,
    output logic                           branch_id,
    output mips_pipe_pkg::alu_op_t         alucontrol_id
);

    logic [mips_isa_pkg::op_width-1:0]    op;
    logic [mips_isa_pkg::funct_width-1:0] funct;
    mips_pipe_pkg::alu_op_t               rtype_op;
    logic                                 rtype_ok;

    assign op    = instr_id[mips_isa_pkg::op_lsb +: mips_isa_pkg::op_width];
    assign funct = instr_id[mips_isa_pkg::funct_width-1:0];

    // ALU decoder for R-type
    always_comb begin
        rtype_ok = 1'b1;
        case (funct)
            mips_isa_pkg::funct_add: rtype_op = mips_pipe_pkg::alu_add;
            mips_isa_pkg::funct_sub: rtype_op = mips_pipe_pkg::alu_sub;
            mips_isa_pkg::funct_and: rtype_op = mips_pipe_pkg::alu_and;
            mips_isa_pkg::funct_or:  rtype_op = mips_pipe_pkg::alu_or;
            mips_isa_pkg::funct_slt: rtype_op = mips_pipe_pkg::alu_slt;
            default: begin
                // Includes the all-zero bubble word
                rtype_op = mips_pipe_pkg::alu_and;
                rtype_ok = 1'b0;
            end
        endcase
    end

    // Main decoder
    always_comb begin
        memtoreg_id   = 1'b0;
        memwrite_id   = 1'b0;
        alusrc_id     = 1'b0;
        regdst_id     = 1'b0;
        regwrite_id   = 1'b0;
        jump_id       = 1'b0;
        branch_id     = 1'b0;
        alucontrol_id = mips_pipe_pkg::alu_and;
        case (op)
            mips_isa_pkg::op_rtype: begin
                regdst_id     = 1'b1;
                regwrite_id   = rtype_ok;
                alucontrol_id = rtype_op;
            end
            mips_isa_pkg::op_lw: begin
                alusrc_id     = 1'b1;
                memtoreg_id   = 1'b1;
                regwrite_id   = 1'b1;
                alucontrol_id = mips_pipe_pkg::alu_add;
            end
            mips_isa_pkg::op_sw: begin
                alusrc_id     = 1'b1;
                memwrite_id   = 1'b1;
                alucontrol_id = mips_pipe_pkg::alu_add;
            end
            mips_isa_pkg::op_beq: begin
                branch_id     = 1'b1;
                alucontrol_id = mips_pipe_pkg::alu_sub;
            end
            mips_isa_pkg::op_addi: begin
                alusrc_id     = 1'b1;
                regwrite_id   = 1'b1;
                alucontrol_id = mips_pipe_pkg::alu_add;
            end
            mips_isa_pkg::op_j: jump_id = 1'b1;
            default: ;
        endcase
    end

endmodule

//--- design/datapath.sv
`timescale 1ns/1ps

module datapath #(
    parameter logic [mips_pipe_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                           clk,
    input  logic                           rst_n,
    output logic [mips_pipe_pkg::xlen-1:0] instr_id,
    input  logic                           memtoreg_id,
    input  logic                           memwrite_id,
    input  logic                           alusrc_id,
    input  logic                           regdst_id,
    input  logic                           regwrite_id,
    input  logic                           jump_id,
    input  logic                           branch_id,
    input  mips_pipe_pkg::alu_op_t         alucontrol_id,
    output logic [mips_pipe_pkg::xlen-1:0] pc_if,
    input  logic [mips_pipe_pkg::xlen-1:0] instr_if,
    output logic [mips_pipe_pkg::xlen-1:0] aluout_mem,
    output logic [mips_pipe_pkg::xlen-1:0] writedata_mem,
    input  logic [mips_pipe_pkg::xlen-1:0] readdata_mem,
    output logic                           memwrite_mem
);

    localparam int xlen = mips_pipe_pkg::xlen;
    localparam int aw   = mips_pipe_pkg::reg_addr_width;
    localparam int iw   = mips_isa_pkg::imm_width;
    localparam int jw   = mips_isa_pkg::jaddr_width;

    logic [xlen-1:0] pcplus4_if, pcnext_if;
    logic            flush_id;
    logic [xlen-1:0] pcplus4_id, pcjump_id, signimm_id, srca_id, writedata_id;
    logic [aw-1:0]   rs_id, rt_id, rd_id;
    logic            memtoreg_ex, memwrite_ex, alusrc_ex, regdst_ex, regwrite_ex, branch_ex;
    mips_pipe_pkg::alu_op_t alucontrol_ex;
    logic [xlen-1:0] pcplus4_ex, srca_ex, writedata_ex, signimm_ex;
    logic [xlen-1:0] srcb_ex, aluout_ex, pcbranch_ex;
    logic [aw-1:0]   rt_ex, rd_ex, writereg_ex;
    logic            zero_ex;
    logic            memtoreg_mem, regwrite_mem, branch_mem, zero_mem, pcsrc_mem;
    logic [xlen-1:0] pcbranch_mem;
    logic [aw-1:0]   writereg_mem;
    logic            memtoreg_wb, regwrite_wb;
    logic [xlen-1:0] aluout_wb, readdata_wb, result_wb;
    logic [aw-1:0]   writereg_wb;
    logic            stall_if, stall_id, stall_ex;

    // Fetch
    assign pcplus4_if = pc_if + xlen'(4);
    assign pcnext_if  = pcsrc_mem ? pcbranch_mem : (jump_id ? pcjump_id : pcplus4_if);

    // A resolving branch redirects even while the PC is held
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_if <= reset_pc;
        end else if (!stall_if || pcsrc_mem) begin
            pc_if <= pcnext_if;
        end
    end

    // Squashed fetch turns into an all-zero word, which decodes as a bubble
    assign flush_id = stall_if || jump_id;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instr_id <= '0;
        end else if (!stall_id) begin
            instr_id <= flush_id ? '0 : instr_if;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_id) begin
            pcplus4_id <= pcplus4_if;
        end
    end

    // Decode
    assign rs_id = instr_id[mips_isa_pkg::rs_lsb +: aw];
    assign rt_id = instr_id[mips_isa_pkg::rt_lsb +: aw];
    assign rd_id = instr_id[mips_isa_pkg::rd_lsb +: aw];

    assign signimm_id = {{(xlen-iw){instr_id[iw-1]}}, instr_id[iw-1:0]};
    assign pcjump_id  = {pcplus4_id[xlen-1:jw+2], instr_id[jw-1:0], 2'b00};

    regfile rf_i (
        .clk (clk),
        .we  (regwrite_wb),
        .ra1 (rs_id),
        .ra2 (rt_id),
        .wa  (writereg_wb),
        .wd  (result_wb),
        .rd1 (srca_id),
        .rd2 (writedata_id)
    );

    // Decode to execute with a bubble on a data stall
    always_ff @(posedge clk) begin
        if (!rst_n || stall_ex) begin
            memtoreg_ex   <= 1'b0;
            memwrite_ex   <= 1'b0;
            alusrc_ex     <= 1'b0;
            regdst_ex     <= 1'b0;
            regwrite_ex   <= 1'b0;
            branch_ex     <= 1'b0;
            alucontrol_ex <= mips_pipe_pkg::alu_and;
        end else begin
            memtoreg_ex   <= memtoreg_id;
            memwrite_ex   <= memwrite_id;
            alusrc_ex     <= alusrc_id;
            regdst_ex     <= regdst_id;
            regwrite_ex   <= regwrite_id;
            branch_ex     <= branch_id;
            alucontrol_ex <= alucontrol_id;
        end
    end

    always_ff @(posedge clk) begin
        pcplus4_ex   <= pcplus4_id;
        srca_ex      <= srca_id;
        writedata_ex <= writedata_id;
        signimm_ex   <= signimm_id;
        rt_ex        <= rt_id;
        rd_ex        <= rd_id;
    end

    // Execute
    assign srcb_ex     = alusrc_ex ? signimm_ex : writedata_ex;
    assign writereg_ex = regdst_ex ? rd_ex : rt_ex;
    assign pcbranch_ex = pcplus4_ex + {signimm_ex[xlen-3:0], 2'b00};

    alu alu_i (
        .a       (srca_ex),
        .b       (srcb_ex),
        .control (alucontrol_ex),
        .result  (aluout_ex),
        .zero    (zero_ex)
    );

    // Execute to memory
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            memtoreg_mem <= 1'b0;
            memwrite_mem <= 1'b0;
            regwrite_mem <= 1'b0;
            branch_mem   <= 1'b0;
        end else begin
            memtoreg_mem <= memtoreg_ex;
            memwrite_mem <= memwrite_ex;
            regwrite_mem <= regwrite_ex;
            branch_mem   <= branch_ex;
        end
    end

    always_ff @(posedge clk) begin
        zero_mem      <= zero_ex;
        aluout_mem    <= aluout_ex;
        writedata_mem <= writedata_ex;
        pcbranch_mem  <= pcbranch_ex;
        writereg_mem  <= writereg_ex;
    end

    // Memory
    assign pcsrc_mem = branch_mem && zero_mem;

    // Memory to writeback
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            memtoreg_wb <= 1'b0;
            regwrite_wb <= 1'b0;
        end else begin
            memtoreg_wb <= memtoreg_mem;
            regwrite_wb <= regwrite_mem;
        end
    end

    always_ff @(posedge clk) begin
        aluout_wb   <= aluout_mem;
        readdata_wb <= readdata_mem;
        writereg_wb <= writereg_mem;
    end

    // Writeback
    assign result_wb = memtoreg_wb ? readdata_wb : aluout_wb;

    hazard_unit hazard_i (
        .rs_id        (rs_id),
        .rt_id        (rt_id),
        .jump_id      (jump_id),
        .branch_id    (branch_id),
        .branch_ex    (branch_ex),
        .regwrite_ex  (regwrite_ex),
        .writereg_ex  (writereg_ex),
        .branch_mem   (branch_mem),
        .regwrite_mem (regwrite_mem),
        .writereg_mem (writereg_mem),
        .stall_if     (stall_if),
        .stall_id     (stall_id),
        .stall_ex     (stall_ex)
    );

endmodule

//--- design/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  logic [mips_pipe_pkg::reg_addr_width-1:0] rs_id,
    input  logic [mips_pipe_pkg::reg_addr_width-1:0] rt_id,
    input  logic                                     jump_id,
    input  logic                                     branch_id,
    input  logic                                     branch_ex,
    input  logic                                     regwrite_ex,
    input  logic [mips_pipe_pkg::reg_addr_width-1:0] writereg_ex,
    input  logic                                     branch_mem,
    input  logic                                     regwrite_mem,
    input  logic [mips_pipe_pkg::reg_addr_width-1:0] writereg_mem,
    output logic                                     stall_if,
    output logic                                     stall_id,
    output logic                                     stall_ex
);

    logic rs_busy;
    logic rt_busy;
    logic data_stall;
    logic branch_busy;

    // Source register still waiting on a write from execute or memory
    function automatic logic pending(
        input logic [mips_pipe_pkg::reg_addr_width-1:0] src
    );
        logic hit_ex;
        logic hit_mem;
        hit_ex  = regwrite_ex && (writereg_ex == src);
        hit_mem = regwrite_mem && (writereg_mem == src);
        return (src != '0) && (hit_ex || hit_mem);
    endfunction

    assign rs_busy = pending(rs_id);
    assign rt_busy = pending(rt_id);

    // The j target field overlaps rs and rt
    assign data_stall = !jump_id && (rs_busy || rt_busy);

    // beq resolves in memory
    assign branch_busy = branch_id || branch_ex || branch_mem;

    assign stall_if = data_stall || branch_busy;
    assign stall_id = data_stall;
    assign stall_ex = data_stall;

endmodule

//--- design/mips_core.sv
`timescale 1ns/1ps

module mips_core #(
    parameter logic [mips_pipe_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                           clk,
    input  logic                           rst_n,
    output logic [mips_pipe_pkg::xlen-1:0] pc,
    input  logic [mips_pipe_pkg::xlen-1:0] instr,
    output logic [mips_pipe_pkg::xlen-1:0] mem_addr,
    output logic [mips_pipe_pkg::xlen-1:0] mem_wdata,
    input  logic [mips_pipe_pkg::xlen-1:0] mem_rdata,
    output logic                           mem_write
);

    logic [mips_pipe_pkg::xlen-1:0] instr_id;
    logic                           memtoreg_id, memwrite_id, alusrc_id, regdst_id;
    logic                           regwrite_id, jump_id, branch_id;
    mips_pipe_pkg::alu_op_t         alucontrol_id;

    controller ctrl_i (
        .instr_id      (instr_id),
        .memtoreg_id   (memtoreg_id),
        .memwrite_id   (memwrite_id),
        .alusrc_id     (alusrc_id),
        .regdst_id     (regdst_id),
        .regwrite_id   (regwrite_id),
        .jump_id       (jump_id),
        .branch_id     (branch_id),
        .alucontrol_id (alucontrol_id)
    );

    datapath #(
        .reset_pc (reset_pc)
    ) dp_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_id      (instr_id),
        .memtoreg_id   (memtoreg_id),
        .memwrite_id   (memwrite_id),
        .alusrc_id     (alusrc_id),
        .regdst_id     (regdst_id),
        .regwrite_id   (regwrite_id),
        .jump_id       (jump_id),
        .branch_id     (branch_id),
        .alucontrol_id (alucontrol_id),
        .pc_if         (pc),
        .instr_if      (instr),
        .aluout_mem    (mem_addr),
        .writedata_mem (mem_wdata),
        .readdata_mem  (mem_rdata),
        .memwrite_mem  (mem_write)
    );

endmodule

//--- design/mips_isa_pkg.sv
package mips_isa_pkg;

    // Instruction field positions and widths
    localparam int op_lsb      = 26;
    localparam int op_width    = 6;
    localparam int rs_lsb      = 21;
    localparam int rt_lsb      = 16;
    localparam int rd_lsb      = 11;
    localparam int funct_width = 6;
    localparam int imm_width   = 16;
    localparam int jaddr_width = 26;

    // Opcodes
    localparam logic [op_width-1:0] op_rtype = 6'b000000;
    localparam logic [op_width-1:0] op_lw    = 6'b100011;
    localparam logic [op_width-1:0] op_sw    = 6'b101011;
    localparam logic [op_width-1:0] op_beq   = 6'b000100;
    localparam logic [op_width-1:0] op_addi  = 6'b001000;
    localparam logic [op_width-1:0] op_j     = 6'b000010;

    // R-type funct field
    localparam logic [funct_width-1:0] funct_add = 6'b100000;
    localparam logic [funct_width-1:0] funct_sub = 6'b100010;
    localparam logic [funct_width-1:0] funct_and = 6'b100100;
    localparam logic [funct_width-1:0] funct_or  = 6'b100101;
    localparam logic [funct_width-1:0] funct_slt = 6'b101010;

endpackage

//--- design/mips_pipe_pkg.sv
package mips_pipe_pkg;

    // Datapath and register file sizes
    localparam int xlen           = 32;
    localparam int reg_addr_width = 5;

    // ALU operations
    // alu_and is the idle value
    typedef enum logic [2:0] {
        alu_and = 3'b000,
        alu_or  = 3'b001,
        alu_add = 3'b010,
        alu_sub = 3'b110,
        alu_slt = 3'b111
    } alu_op_t;

endpackage

//--- design/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                                     clk,
    input  logic                                     we,
    input  logic [mips_pipe_pkg::reg_addr_width-1:0] ra1,
    input  logic [mips_pipe_pkg::reg_addr_width-1:0] ra2,
    input  logic [mips_pipe_pkg::reg_addr_width-1:0] wa,
    input  logic [mips_pipe_pkg::xlen-1:0]           wd,
    output logic [mips_pipe_pkg::xlen-1:0]           rd1,
    output logic [mips_pipe_pkg::xlen-1:0]           rd2
);

    logic [mips_pipe_pkg::xlen-1:0] regs [2**mips_pipe_pkg::reg_addr_width];

    always_ff @(posedge clk) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // Writeback in the same cycle is seen by decode
    assign rd1 = (ra1 == '0) ? '0 : ((we && wa == ra1) ? wd : regs[ra1]);
    assign rd2 = (ra2 == '0) ? '0 : ((we && wa == ra2) ? wd : regs[ra2]);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the MIPS core testbench with Verilator

top=mips_core_tb
log=sim.log

verilator --binary --assert -Wno-fatal --top-module "$top" -f build.f -o "$top"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"

if grep -q "sim failed" "$log"; then
    echo "FAIL: testbench reported an error"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "FAIL: simulator exited with status $status"
    exit 1
fi

echo "PASS"
exit 0

//--- sim/mips_core_tb.sv
`timescale 1ns/1ps

module mips_core_tb;

    // ROM is 64 words, so the program at word 0 runs from reset_pc
    localparam logic [31:0] reset_pc  = 32'h0000_0100;
    localparam int          rom_words = 64;
    localparam int          ram_words = 128;

    logic        clk;
    logic        rst_n;
    logic        load;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        mem_write;
    logic [31:0] prog [rom_words];
    logic [31:0] data_init [ram_words];

    // Stores still to come as {address, data}
    logic [63:0] expected [$];
    int          store_idx;
    logic        exp_valid;
    logic [63:0] exp_pair;
    int          prog_len;
    int          seed;
    string       test_name;

    always #4 clk = ~clk;

    mips_core #(
        .reset_pc (reset_pc)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc        (pc),
        .instr     (instr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_write (mem_write)
    );

    tb_mem #(
        .rom_words (rom_words),
        .ram_words (ram_words)
    ) mem_i (
        .clk       (clk),
        .load      (load),
        .prog      (prog),
        .data_init (data_init),
        .pc        (pc),
        .instr     (instr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_write (mem_write)
    );

    // A store leaves memory at the edge that ends its cycle
    always @(posedge clk) begin
        int next_idx;
        if (!rst_n) begin
            next_idx = 0;
        end else if (mem_write) begin
            next_idx = store_idx + 1;
        end else begin
            next_idx = store_idx;
        end
        store_idx <= next_idx;
        if (next_idx < expected.size()) begin
            exp_valid <= 1'b1;
            exp_pair  <= expected[next_idx];
        end else begin
            exp_valid <= 1'b0;
            exp_pair  <= '0;
        end
    end

    // Sampled mid-cycle, when the memory stage is stable
    store_expected: assert property (@(negedge clk) disable iff (!rst_n)
        mem_write |-> exp_valid)
        else fail_run($sformatf("store to %h in %s when no further store was expected",
            mem_addr, test_name));

    store_value: assert property (@(negedge clk) disable iff (!rst_n)
        (mem_write && exp_valid) |-> (mem_addr == exp_pair[63:32] && mem_wdata == exp_pair[31:0]))
        else fail_run($sformatf("mismatch %s store expected %h:%h actual %h:%h", test_name,
            exp_pair[63:32], exp_pair[31:0], mem_addr, mem_wdata));

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] rtype_word(input logic [5:0] funct, input int rd,
                                              input int rs, input int rt);
        return {mips_isa_pkg::op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'b0, funct};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input int rt,
                                              input int rs, input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] beq_word(input int rs, input int rt, input int at,
                                            input int target);
        return itype_word(mips_isa_pkg::op_beq, rt, rs, target - at - 1);
    endfunction

    // Absolute word index of a program slot
    function automatic logic [31:0] jump_word(input int target);
        return {mips_isa_pkg::op_j, 26'((reset_pc >> 2) + 32'(target))};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic expect_store(input int addr, input logic [31:0] data);
        expected.push_back({32'(addr), data});
    endtask

    task automatic begin_program(input string name);
        int i;
        @(posedge clk);
        #1;
        rst_n     = 1'b0;
        test_name = name;
        prog_len  = 0;
        expected.delete();
        for (i = 0; i < rom_words; i++) begin
            prog[i] = '0;
        end
        for (i = 0; i < ram_words; i++) begin
            data_init[i] = {16'hd0d0, 16'(i * 4)};
        end
    endtask

    task automatic run_program(input bit check_pc, input int max_cycles);
        int i;
        int n;
        load = 1'b1;
        repeat (5) begin
            @(posedge clk);
            #1;
            assert (!mem_write)
                else fail_run($sformatf("mem_write was high during reset in %s", test_name));
        end
        load  = 1'b0;
        rst_n = 1'b1;
        if (check_pc) begin
            // Straight-line code with no hazards, one fetch per cycle
            for (i = 0; i < 5; i++) begin
                assert (pc == reset_pc + 32'(4 * i))
                    else fail_run($sformatf("mismatch %s pc expected %h actual %h", test_name,
                        reset_pc + 32'(4 * i), pc));
                @(posedge clk);
                #1;
            end
        end
        n = 0;
        while (store_idx < expected.size()) begin
            if (n == max_cycles) begin
                fail_run($sformatf("timeout in %s, only %0d of %0d stores seen in %0d cycles",
                    test_name, store_idx, expected.size(), max_cycles));
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        int i;
        clk       = 1'b0;
        rst_n     = 1'b0;
        load      = 1'b0;
        seed      = 32'h31ac;
        prog_len  = 0;
        test_name = "init";

        begin_program("arith");
        emit(itype_word(mips_isa_pkg::op_addi, 1, 0, 5));
        emit(itype_word(mips_isa_pkg::op_addi, 2, 0, 12));
        emit(itype_word(mips_isa_pkg::op_addi, 3, 0, -3));
        emit(itype_word(mips_isa_pkg::op_addi, 4, 0, 7));
        emit(itype_word(mips_isa_pkg::op_addi, 5, 0, 'h50));
        emit(rtype_word(mips_isa_pkg::funct_add, 6, 1, 2));
        emit(rtype_word(mips_isa_pkg::funct_sub, 7, 6, 3));
        emit(rtype_word(mips_isa_pkg::funct_and, 8, 7, 4));
        emit(rtype_word(mips_isa_pkg::funct_or, 9, 8, 5));
        emit(rtype_word(mips_isa_pkg::funct_slt, 10, 3, 9));
        emit(itype_word(mips_isa_pkg::op_addi, 11, 10, -9));
        for (i = 6; i <= 11; i++) begin
            emit(itype_word(mips_isa_pkg::op_sw, i, 0, 4 * (i - 6)));
        end
        emit(jump_word(prog_len));
        a = 32'd5 + 32'd12;
        expect_store(0, a);
        b = a - 32'hffff_fffd;
        expect_store(4, b);
        a = b & 32'd7;
        expect_store(8, a);
        b = a | 32'h50;
        expect_store(12, b);
        a = ($signed(32'hffff_fffd) < $signed(b)) ? 32'd1 : 32'd0;
        expect_store(16, a);
        expect_store(20, a - 32'd9);
        run_program(1'b1, 500);

        begin_program("load_store");
        emit(itype_word(mips_isa_pkg::op_addi, 1, 0, 'h1234));
        emit(itype_word(mips_isa_pkg::op_addi, 2, 0, 25));
        emit(itype_word(mips_isa_pkg::op_sw, 1, 0, 32));
        emit(itype_word(mips_isa_pkg::op_lw, 3, 0, 32));
        emit(rtype_word(mips_isa_pkg::funct_add, 4, 3, 2));
        emit(itype_word(mips_isa_pkg::op_sw, 4, 0, 36));
        emit(jump_word(prog_len));
        expect_store(32, 32'h1234);
        expect_store(36, 32'h1234 + 32'd25);
        run_program(1'b0, 500);

        begin_program("branch");
        emit(itype_word(mips_isa_pkg::op_addi, 1, 0, 9));
        emit(itype_word(mips_isa_pkg::op_addi, 2, 0, 9));
        emit(itype_word(mips_isa_pkg::op_addi, 3, 0, 4));
        emit(beq_word(1, 2, 3, 5));
        emit(itype_word(mips_isa_pkg::op_sw, 3, 0, 40));
        emit(beq_word(1, 3, 5, 7));
        emit(itype_word(mips_isa_pkg::op_sw, 1, 0, 44));
        emit(beq_word(0, 0, 7, 10));
        emit(itype_word(mips_isa_pkg::op_sw, 2, 0, 48));
        emit(itype_word(mips_isa_pkg::op_sw, 2, 0, 52));
        emit(itype_word(mips_isa_pkg::op_sw, 3, 0, 56));
        emit(rtype_word(mips_isa_pkg::funct_add, 4, 1, 3));
        emit(itype_word(mips_isa_pkg::op_sw, 4, 0, 60));
        emit(jump_word(prog_len));
        expect_store(44, 32'd9);
        expect_store(56, 32'd4);
        expect_store(60, 32'd13);
        run_program(1'b0, 500);

        begin_program("jump");
        emit(itype_word(mips_isa_pkg::op_addi, 1, 0, 77));
        emit(jump_word(3));
        emit(itype_word(mips_isa_pkg::op_sw, 1, 0, 64));
        emit(itype_word(mips_isa_pkg::op_sw, 1, 0, 68));
        emit(itype_word(mips_isa_pkg::op_addi, 2, 1, 1));
        emit(itype_word(mips_isa_pkg::op_sw, 2, 0, 72));
        emit(jump_word(prog_len));
        expect_store(68, 32'd77);
        expect_store(72, 32'd78);
        run_program(1'b0, 500);

        // Ten pairs from byte 128 and three results per pair from byte 256
        begin_program("random");
        emit(itype_word(mips_isa_pkg::op_addi, 10, 0, 0));
        emit(itype_word(mips_isa_pkg::op_addi, 11, 0, 0));
        emit(itype_word(mips_isa_pkg::op_addi, 13, 0, 80));
        emit(itype_word(mips_isa_pkg::op_lw, 1, 10, 128));
        emit(itype_word(mips_isa_pkg::op_lw, 2, 10, 132));
        emit(rtype_word(mips_isa_pkg::funct_add, 3, 1, 2));
        emit(rtype_word(mips_isa_pkg::funct_sub, 4, 1, 2));
        emit(rtype_word(mips_isa_pkg::funct_slt, 5, 1, 2));
        emit(itype_word(mips_isa_pkg::op_sw, 3, 11, 256));
        emit(itype_word(mips_isa_pkg::op_sw, 4, 11, 260));
        emit(itype_word(mips_isa_pkg::op_sw, 5, 11, 264));
        emit(itype_word(mips_isa_pkg::op_addi, 10, 10, 8));
        emit(itype_word(mips_isa_pkg::op_addi, 11, 11, 12));
        emit(beq_word(10, 13, 13, 15));
        emit(jump_word(3));
        emit(jump_word(prog_len));
        for (i = 0; i < 10; i++) begin
            a = $random(seed);
            b = $random(seed);
            data_init[32 + 2 * i] = a;
            data_init[33 + 2 * i] = b;
            expect_store(256 + 12 * i, a + b);
            expect_store(260 + 12 * i, a - b);
            expect_store(264 + 12 * i, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        end
        run_program(1'b0, 2000);

        $display("sim passed");
        $finish;
    end

endmodule

//--- sim/tb_mem.sv
`timescale 1ns/1ps

module tb_mem #(
    parameter int rom_words = 64,
    parameter int ram_words = 128
) (
    input  logic        clk,
    input  logic        load,
    input  logic [31:0] prog [rom_words],
    input  logic [31:0] data_init [ram_words],
    input  logic [31:0] pc,
    output logic [31:0] instr,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    output logic [31:0] mem_rdata,
    input  logic        mem_write
);

    localparam int rom_aw = $clog2(rom_words);
    localparam int ram_aw = $clog2(ram_words);

    logic [31:0] rom [rom_words];
    logic [31:0] ram [ram_words];

    initial begin
        for (int i = 0; i < rom_words; i++) begin
            rom[i] = '0;
        end
        for (int i = 0; i < ram_words; i++) begin
            ram[i] = '0;
        end
    end

    // Only the low address bits are decoded, so both memories alias
    assign instr     = rom[pc[rom_aw+1:2]];
    assign mem_rdata = ram[mem_addr[ram_aw+1:2]];

    always @(posedge clk) begin
        if (load) begin
            for (int i = 0; i < rom_words; i++) begin
                rom[i] <= prog[i];
            end
            for (int i = 0; i < ram_words; i++) begin
                ram[i] <= data_init[i];
            end
        end else if (mem_write) begin
            ram[mem_addr[ram_aw+1:2]] <= mem_wdata;
        end
    end

endmodule
